//--- cart_top.f
+incdir+src
src/cart_pkg.sv
src/snes_bus_sync.sv
src/address_map.sv
src/rom_arbiter.sv
src/cart_top.sv
verification/psram_model.sv
verification/tb_cart_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cart_top testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f cart_top.f --top-module tb_cart_top -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  || echo "Verilator build or simulation run failed"

grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src/address_map.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module address_map (
  input  cart_pkg::snes_addr_u snes_addr,
  input  cart_pkg::cart_cfg_t  cfg,
  output cart_pkg::region_t    region
);

  logic        hi_rom;
  logic        hi_sram;
  logic        lo_rom;
  logic        lo_sram;
  logic [23:0] hi_rom_addr;
  logic [23:0] hi_sram_addr;
  logic [23:0] lo_rom_addr;
  logic [23:0] lo_sram_addr;

  //////////////////////////////////////////////////
  // HiROM
  //////////////////////////////////////////////////

  // Banks 40-7F and C0-FF in full, upper half elsewhere
  assign hi_rom = snes_addr.raw[22] | snes_addr.raw[15];

  // Banks 20-3F and A0-BF, offsets 6000-7FFF
  assign hi_sram = (snes_addr.f.bank[6:5] == 2'b01)
                 & (snes_addr.f.offset[15:13] == 3'b011);

  assign hi_rom_addr = {2'b00, snes_addr.raw[21:0]} & cfg.rom_mask;

  assign hi_sram_addr = `CART_SAVERAM_BASE
                      + ({6'd0, snes_addr.f.bank[4:0], snes_addr.f.offset[12:0]}
                         & cfg.saveram_mask);

  //////////////////////////////////////////////////
  // LoROM
  //////////////////////////////////////////////////

  assign lo_rom = snes_addr.raw[15];

  // Banks 70-7D, lower half of the bank
  assign lo_sram = (snes_addr.f.bank[7:4] == 4'h7)
                 & (snes_addr.f.bank[3:1] != 3'b111)
                 & ~snes_addr.f.offset[15];

  // 32K pages packed together, A15 dropped
  assign lo_rom_addr = {2'b00, snes_addr.raw[22:16], snes_addr.raw[14:0]} & cfg.rom_mask;

  assign lo_sram_addr = `CART_SAVERAM_BASE
                      + ({5'd0, snes_addr.f.bank[3:0], snes_addr.f.offset[14:0]}
                         & cfg.saveram_mask);

  //////////////////////////////////////////////////
  // Mapper select
  //////////////////////////////////////////////////

  always_comb begin
    if (cfg.mapper) begin
      region.is_rom     = lo_rom;
      region.is_saveram = lo_sram;
      region.addr       = lo_sram ? lo_sram_addr : lo_rom_addr;
    end else begin
      region.is_rom     = hi_rom;
      region.is_saveram = hi_sram;
      region.addr       = hi_sram ? hi_sram_addr : hi_rom_addr;
    end
    // Only save RAM takes console writes
    region.is_writable = region.is_saveram;
  end

endmodule

`default_nettype wire

//--- src/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// Strobe history length in CLK2 cycles
`define CART_SYNC_DEPTH 6

// PSRAM wait counts, in CLK2 cycles per wait phase
`define CART_RD_WAIT 4'd4
`define CART_WR_WAIT1 4'd2
`define CART_WR_WAIT2 4'd3

// Host and coprocessor access, base wait
`define CART_HOST_WAIT 4'd6

// Save RAM lives at the top of PSRAM
`define CART_SAVERAM_BASE 24'hE00000

`endif

//--- src/cart_pkg.sv
`default_nettype none

package cart_pkg;

  // Console address seen as bank and offset
  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset;
  } snes_bank_addr_t;

  typedef union packed {
    logic [23:0]     raw;
    snes_bank_addr_t f;
  } snes_addr_u;

  // Mapper 0 is HiROM, 1 is LoROM
  typedef struct packed {
    logic        mapper;
    logic [23:0] rom_mask;
    logic [23:0] saveram_mask;
  } cart_cfg_t;

  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  wdata;
    logic        write;
  } mem_req_t;

  typedef struct packed {
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic [23:0] addr;
  } region_t;

  // PSRAM control and address, active low strobes
  typedef struct packed {
    logic [22:0] addr;
    logic [15:0] wdata;
    logic        we_n;
    logic        bhe_n;
    logic        ble_n;
  } psram_bus_t;

endpackage

`default_nettype wire

//--- src/cart_top.sv
`timescale 1ns/1ps
`default_nettype none

module cart_top (
  input  logic                 CLK2,
  input  logic                 reset,
  input  logic [23:0]          snes_addr,
  input  logic                 snes_rd_n,
  input  logic                 snes_wr_n,
  input  logic                 snes_cpu_clk,
  input  logic [7:0]           snes_din,
  output logic [7:0]           snes_dout,
  output logic                 snes_data_oe,
  output logic                 snes_databus_dir,
  input  cart_pkg::cart_cfg_t  cfg,
  input  logic                 mcu_req,
  input  cart_pkg::mem_req_t   mcu_cmd,
  output logic                 mcu_ack,
  output logic [7:0]           mcu_rdata,
  input  logic                 cop_req,
  input  logic [23:0]          cop_addr,
  output logic                 cop_ack,
  output logic [7:0]           cop_rdata,
  output cart_pkg::psram_bus_t psram,
  input  logic [15:0]          psram_rdata,
  output logic                 psram_dout_oe
);

  logic               cycle_start;
  logic               wr_start;
  logic               cycle_end;
  cart_pkg::region_t  region;

  snes_bus_sync i_sync (
    .CLK2         (CLK2),
    .reset        (reset),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_cpu_clk (snes_cpu_clk),
    .cycle_start  (cycle_start),
    .wr_start     (wr_start),
    .cycle_end    (cycle_end)
  );

  address_map i_map (
    .snes_addr (snes_addr),
    .cfg       (cfg),
    .region    (region)
  );

  rom_arbiter i_arb (
    .CLK2          (CLK2),
    .reset         (reset),
    .cycle_start   (cycle_start),
    .wr_start      (wr_start),
    .cycle_end     (cycle_end),
    .region        (region),
    .snes_din      (snes_din),
    .snes_dout     (snes_dout),
    .mcu_req       (mcu_req),
    .mcu_cmd       (mcu_cmd),
    .mcu_ack       (mcu_ack),
    .mcu_rdata     (mcu_rdata),
    .cop_req       (cop_req),
    .cop_addr      (cop_addr),
    .cop_ack       (cop_ack),
    .cop_rdata     (cop_rdata),
    .psram         (psram),
    .psram_rdata   (psram_rdata),
    .psram_dout_oe (psram_dout_oe)
  );

  // Drive the console bus only for reads that hit the cart
  assign snes_data_oe     = ~snes_rd_n & (region.is_rom | region.is_saveram);
  assign snes_databus_dir = ~snes_rd_n;

endmodule

`default_nettype wire

//--- src/rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module rom_arbiter (
  input  logic                 CLK2,
  input  logic                 reset,
  input  logic                 cycle_start,
  input  logic                 wr_start,
  input  logic                 cycle_end,
  input  cart_pkg::region_t    region,
  input  logic [7:0]           snes_din,
  output logic [7:0]           snes_dout,
  input  logic                 mcu_req,
  input  cart_pkg::mem_req_t   mcu_cmd,
  output logic                 mcu_ack,
  output logic [7:0]           mcu_rdata,
  input  logic                 cop_req,
  input  logic [23:0]          cop_addr,
  output logic                 cop_ack,
  output logic [7:0]           cop_rdata,
  output cart_pkg::psram_bus_t psram,
  input  logic [15:0]          psram_rdata,
  output logic                 psram_dout_oe
);

  //////////////////////////////////////////////////
  // One-hot states
  //////////////////////////////////////////////////

  localparam logic [17:0] ST_IDLE      = 18'd1 << 0;
  localparam logic [17:0] ST_SRD_ADDR  = 18'd1 << 1;
  localparam logic [17:0] ST_SRD_WAIT  = 18'd1 << 2;
  localparam logic [17:0] ST_SRD_END   = 18'd1 << 3;
  localparam logic [17:0] ST_SWR_ADDR  = 18'd1 << 4;
  localparam logic [17:0] ST_SWR_WAIT1 = 18'd1 << 5;
  localparam logic [17:0] ST_SWR_DATA  = 18'd1 << 6;
  localparam logic [17:0] ST_SWR_WAIT2 = 18'd1 << 7;
  localparam logic [17:0] ST_SWR_END   = 18'd1 << 8;
  localparam logic [17:0] ST_MRD_ADDR  = 18'd1 << 9;
  localparam logic [17:0] ST_MRD_WAIT  = 18'd1 << 10;
  localparam logic [17:0] ST_MRD_END   = 18'd1 << 11;
  localparam logic [17:0] ST_MWR_ADDR  = 18'd1 << 12;
  localparam logic [17:0] ST_MWR_WAIT  = 18'd1 << 13;
  localparam logic [17:0] ST_MWR_END   = 18'd1 << 14;
  localparam logic [17:0] ST_CRD_ADDR  = 18'd1 << 15;
  localparam logic [17:0] ST_CRD_WAIT  = 18'd1 << 16;
  localparam logic [17:0] ST_CRD_END   = 18'd1 << 17;

  localparam logic [17:0] CONSOLE_STATES = ST_SRD_ADDR | ST_SRD_WAIT | ST_SRD_END
                                         | ST_SWR_ADDR | ST_SWR_WAIT1 | ST_SWR_DATA
                                         | ST_SWR_WAIT2 | ST_SWR_END;
  localparam logic [17:0] WRITE_STATES = ST_SWR_ADDR | ST_SWR_WAIT1 | ST_SWR_DATA
                                       | ST_SWR_WAIT2 | ST_SWR_END | ST_MWR_WAIT;

  logic [17:0] state;
  logic [3:0]  wait_cnt;
  logic        wait_done;
  logic        we_n;
  logic [23:0] addr_q;
  logic [7:0]  wdata_q;
  logic [7:0]  lane_byte;
  logic        in_cart;
  logic        console_busy;

  assign in_cart      = region.is_rom | region.is_saveram;
  assign console_busy = |(state & CONSOLE_STATES);
  assign wait_done    = (wait_cnt == 4'd1);

  // Bit 0 set picks the low byte
  assign lane_byte = addr_q[0] ? psram_rdata[7:0] : psram_rdata[15:8];

  //////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state    <= ST_IDLE;
      wait_cnt <= 4'd0;
      we_n     <= 1'b1;
      mcu_ack  <= 1'b0;
      cop_ack  <= 1'b0;
    end else begin
      if (wait_cnt != 4'd0) begin
        wait_cnt <= wait_cnt - 4'd1;
      end
      // Four-phase release
      if (!mcu_req) begin
        mcu_ack <= 1'b0;
      end
      if (!cop_req) begin
        cop_ack <= 1'b0;
      end

      // Console always wins; an interrupted host access reruns later
      if (wr_start & in_cart) begin
        state  <= ST_SWR_ADDR;
        addr_q <= region.addr;
        we_n   <= ~region.is_writable;
      end else if (cycle_start & in_cart) begin
        state  <= ST_SRD_ADDR;
        addr_q <= region.addr;
        we_n   <= 1'b1;
      end else if (cycle_end & console_busy) begin
        // Console cycle over, drop whatever is left of it
        state <= ST_IDLE;
        we_n  <= 1'b1;
      end else begin
        case (state)
          ST_IDLE: begin
            if (cop_req & ~cop_ack) begin
              state <= ST_CRD_ADDR;
            end else if (mcu_req & ~mcu_ack) begin
              state <= mcu_cmd.write ? ST_MWR_ADDR : ST_MRD_ADDR;
            end
          end
          ST_SRD_ADDR: begin
            wait_cnt <= `CART_RD_WAIT;
            state    <= ST_SRD_WAIT;
          end
          ST_SRD_WAIT: begin
            if (wait_done) state <= ST_SRD_END;
          end
          ST_SRD_END: begin
            snes_dout <= lane_byte;
            state     <= ST_IDLE;
          end
          ST_SWR_ADDR: begin
            wait_cnt <= `CART_WR_WAIT1;
            state    <= ST_SWR_WAIT1;
          end
          ST_SWR_WAIT1: begin
            if (wait_done) state <= ST_SWR_DATA;
          end
          ST_SWR_DATA: begin
            wdata_q  <= snes_din;
            wait_cnt <= `CART_WR_WAIT2;
            state    <= ST_SWR_WAIT2;
          end
          ST_SWR_WAIT2: begin
            if (wait_done) state <= ST_SWR_END;
          end
          ST_SWR_END: begin
            we_n  <= 1'b1;
            state <= ST_IDLE;
          end
          ST_MRD_ADDR: begin
            addr_q   <= mcu_cmd.addr;
            wait_cnt <= `CART_HOST_WAIT + 4'd2;
            state    <= ST_MRD_WAIT;
          end
          ST_MRD_WAIT: begin
            if (wait_done) state <= ST_MRD_END;
          end
          ST_MRD_END: begin
            mcu_rdata <= lane_byte;
            mcu_ack   <= 1'b1;
            state     <= ST_IDLE;
          end
          ST_MWR_ADDR: begin
            addr_q   <= mcu_cmd.addr;
            wdata_q  <= mcu_cmd.wdata;
            we_n     <= 1'b0;
            wait_cnt <= `CART_HOST_WAIT + 4'd2;
            state    <= ST_MWR_WAIT;
          end
          ST_MWR_WAIT: begin
            if (wait_done) begin
              we_n  <= 1'b1;
              state <= ST_MWR_END;
            end
          end
          ST_MWR_END: begin
            mcu_ack <= 1'b1;
            state   <= ST_IDLE;
          end
          ST_CRD_ADDR: begin
            addr_q   <= cop_addr;
            wait_cnt <= `CART_HOST_WAIT + 4'd2;
            state    <= ST_CRD_WAIT;
          end
          ST_CRD_WAIT: begin
            if (wait_done) state <= ST_CRD_END;
          end
          ST_CRD_END: begin
            cop_rdata <= lane_byte;
            cop_ack   <= 1'b1;
            state     <= ST_IDLE;
          end
          default: begin
            state <= ST_IDLE;
            we_n  <= 1'b1;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // PSRAM side
  //////////////////////////////////////////////////

  assign psram.addr    = addr_q[23:1];
  assign psram.wdata   = {wdata_q, wdata_q};
  assign psram.we_n    = we_n;
  // Reads enable both lanes, writes only the addressed one
  assign psram.bhe_n   = ~we_n ? addr_q[0] : 1'b0;
  assign psram.ble_n   = ~we_n ? ~addr_q[0] : 1'b0;
  assign psram_dout_oe = ~we_n;

  a_mcu_ack_req: assert property (@(posedge CLK2) disable iff (reset)
    $rose(mcu_ack) |-> $past(mcu_req));

  a_cop_ack_req: assert property (@(posedge CLK2) disable iff (reset)
    $rose(cop_ack) |-> $past(cop_req));

  a_we_in_write: assert property (@(posedge CLK2) disable iff (reset)
    !psram.we_n |-> |(state & WRITE_STATES));

  a_one_ack: assert property (@(posedge CLK2) disable iff (reset)
    $onehot0({mcu_ack, cop_ack}));

endmodule

`default_nettype wire

//--- src/snes_bus_sync.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module snes_bus_sync (
  input  logic CLK2,
  input  logic reset,
  input  logic snes_rd_n,
  input  logic snes_wr_n,
  input  logic snes_cpu_clk,
  output logic cycle_start,
  output logic wr_start,
  output logic cycle_end
);

  localparam int SYNC_D = `CART_SYNC_DEPTH;

  // Oldest sample in the top bit
  localparam logic [SYNC_D-1:0] PAT_RISE = {1'b0, {(SYNC_D - 1){1'b1}}};
  localparam logic [SYNC_D-1:0] PAT_FALL = {1'b1, {(SYNC_D - 1){1'b0}}};

  logic [SYNC_D-1:0] rd_hist;
  logic [SYNC_D-1:0] wr_hist;
  logic [SYNC_D-1:0] clk_hist;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_hist  <= '1;
      wr_hist  <= '1;
      // Current clock level everywhere, so no edge right after reset
      clk_hist <= {SYNC_D{snes_cpu_clk}};
    end else begin
      rd_hist  <= {rd_hist[SYNC_D-2:0], snes_rd_n};
      wr_hist  <= {wr_hist[SYNC_D-2:0], snes_wr_n};
      clk_hist <= {clk_hist[SYNC_D-2:0], snes_cpu_clk};
    end
  end

  // An edge only counts once the new level has held for the whole history
  assign cycle_start = (clk_hist == PAT_RISE);
  assign cycle_end   = (clk_hist == PAT_FALL);
  // No write while the read strobe has been active
  assign wr_start    = (wr_hist == PAT_FALL) & (rd_hist == '1);

endmodule

`default_nettype wire

//--- verification/psram_model.sv
`timescale 1ns/1ps
`default_nettype none

module psram_model (
  input  logic                 CLK2,
  input  cart_pkg::psram_bus_t psram,
  input  logic                 psram_dout_oe,
  output logic [15:0]          psram_rdata
);

  // 8M words of 16 bits
  logic [15:0] mem [0:8388607];

  // Every clock with we_n low is a write, per byte lane
  always_ff @(posedge CLK2) begin
    if (!psram.we_n && psram_dout_oe) begin
      if (!psram.bhe_n) begin
        mem[psram.addr][15:8] <= psram.wdata[15:8];
      end
      if (!psram.ble_n) begin
        mem[psram.addr][7:0] <= psram.wdata[7:0];
      end
    end
  end

  // Shared data bus, the controller wins while it drives
  assign psram_rdata = psram_dout_oe ? psram.wdata : mem[psram.addr];

endmodule

`default_nettype wire

//--- verification/tb_cart_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module tb_cart_top;

  localparam int TIMEOUT   = 200;
  localparam int RAND_RUNS = 20;

  typedef enum logic [2:0] {SNES_RD, SNES_WR, MCU_RD, MCU_WR, COP_RD, CHECK_OE} kind_e;

  typedef struct {
    kind_e       kind;
    logic        lorom;
    logic [23:0] addr;
    logic [7:0]  data;
    logic [7:0]  expected;
    string       name;
  } entry_t;

  logic                 CLK2;
  logic                 reset;
  logic [23:0]          snes_addr;
  logic                 snes_rd_n;
  logic                 snes_wr_n;
  logic                 snes_cpu_clk;
  logic [7:0]           snes_din;
  logic [7:0]           snes_dout;
  logic                 snes_data_oe;
  logic                 snes_databus_dir;
  cart_pkg::cart_cfg_t  cfg;
  logic                 mcu_req;
  cart_pkg::mem_req_t   mcu_cmd;
  logic                 mcu_ack;
  logic [7:0]           mcu_rdata;
  logic                 cop_req;
  logic [23:0]          cop_addr;
  logic                 cop_ack;
  logic [7:0]           cop_rdata;
  cart_pkg::psram_bus_t psram;
  logic [15:0]          psram_rdata;
  logic                 psram_dout_oe;

  entry_t stim_q[$];

  cart_top i_dut (
    .CLK2             (CLK2),
    .reset            (reset),
    .snes_addr        (snes_addr),
    .snes_rd_n        (snes_rd_n),
    .snes_wr_n        (snes_wr_n),
    .snes_cpu_clk     (snes_cpu_clk),
    .snes_din         (snes_din),
    .snes_dout        (snes_dout),
    .snes_data_oe     (snes_data_oe),
    .snes_databus_dir (snes_databus_dir),
    .cfg              (cfg),
    .mcu_req          (mcu_req),
    .mcu_cmd          (mcu_cmd),
    .mcu_ack          (mcu_ack),
    .mcu_rdata        (mcu_rdata),
    .cop_req          (cop_req),
    .cop_addr         (cop_addr),
    .cop_ack          (cop_ack),
    .cop_rdata        (cop_rdata),
    .psram            (psram),
    .psram_rdata      (psram_rdata),
    .psram_dout_oe    (psram_dout_oe)
  );

  psram_model i_psram (
    .CLK2          (CLK2),
    .psram         (psram),
    .psram_dout_oe (psram_dout_oe),
    .psram_rdata   (psram_rdata)
  );

  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic step();
    @(posedge CLK2);
    #5;
  endtask

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Console address to PSRAM byte address under the selected mapper
  function automatic logic [23:0] map_addr(input logic lorom, input logic [23:0] a);
    logic [7:0]  bank;
    logic [15:0] off;
    bank = a[23:16];
    off  = a[15:0];
    if (!lorom) begin
      if (((bank >= 8'h20 && bank <= 8'h3F) || (bank >= 8'hA0 && bank <= 8'hBF))
          && off >= 16'h6000 && off <= 16'h7FFF) begin
        return `CART_SAVERAM_BASE + ({6'd0, bank[4:0], off[12:0]} & cfg.saveram_mask);
      end
      return {2'b00, a[21:0]} & cfg.rom_mask;
    end
    if (bank >= 8'h70 && bank <= 8'h7D && off < 16'h8000) begin
      return `CART_SAVERAM_BASE + ({5'd0, bank[3:0], off[14:0]} & cfg.saveram_mask);
    end
    return {2'b00, a[22:16], a[14:0]} & cfg.rom_mask;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      abort($sformatf("Fail %s expected %02h actual %02h", name, exp, act));
    end
  endtask

  task automatic check_region_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort($sformatf("Fail %s expected %0b actual %0b", name, exp, act));
    end
  endtask

  task automatic check_mem_req_ack(input string name, input cart_pkg::mem_req_t req,
                                   input logic exp, input logic act);
    if (act !== exp) begin
      abort($sformatf("Fail %s addr %06h expected ack %0b actual ack %0b",
                      name, req.addr, exp, act));
    end
  endtask

  task automatic wait_ack(input logic cop, input logic level, input string name);
    int n;
    n = 0;
    while ((cop ? cop_ack : mcu_ack) !== level) begin
      step();
      n++;
      if (n >= TIMEOUT) begin
        abort($sformatf("Timeout in %s, %s never went %s", name,
                        cop ? "cop_ack" : "mcu_ack", level ? "high" : "low"));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic mcu_access(input string name, input logic write, input logic [23:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    cart_pkg::mem_req_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.write = write;
    check_mem_req_ack(name, req, 1'b0, mcu_ack);
    mcu_cmd = req;
    mcu_req = 1'b1;
    wait_ack(1'b0, 1'b1, name);
    rdata   = mcu_rdata;
    mcu_req = 1'b0;
    wait_ack(1'b0, 1'b0, name);
  endtask

  task automatic cop_read(input string name, input logic [23:0] addr, output logic [7:0] rdata);
    cart_pkg::mem_req_t req;
    req.addr  = addr;
    req.wdata = 8'h00;
    req.write = 1'b0;
    check_mem_req_ack(name, req, 1'b0, cop_ack);
    cop_addr = addr;
    cop_req  = 1'b1;
    wait_ack(1'b1, 1'b1, name);
    rdata = cop_rdata;
    // Only one port acknowledged at a time
    check_mem_req_ack({name, "_mcu_idle"}, req, 1'b0, mcu_ack);
    cop_req = 1'b0;
    wait_ack(1'b1, 1'b0, name);
  endtask

  // CPU clock low for 8 and high for 16 with the strobe active while high
  task automatic snes_cycle(input logic [23:0] addr, input logic write, input logic [7:0] din,
                            output logic [7:0] dout);
    snes_addr    = addr;
    snes_din     = din;
    snes_cpu_clk = 1'b0;
    repeat (8) step();
    snes_cpu_clk = 1'b1;
    snes_rd_n    = write;
    snes_wr_n    = ~write;
    repeat (16) step();
    snes_cpu_clk = 1'b0;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    // Sampled while the end-of-cycle pulse is up
    repeat (`CART_SYNC_DEPTH - 1) step();
    dout = snes_dout;
  endtask

  task automatic add_stim(input kind_e kind, input logic lorom, input logic [23:0] addr,
                          input logic [7:0] data, input logic [7:0] expected, input string name);
    entry_t e;
    e.kind     = kind;
    e.lorom    = lorom;
    e.addr     = addr;
    e.data     = data;
    e.expected = expected;
    e.name     = name;
    stim_q.push_back(e);
  endtask

  task automatic load_stim();
    // Byte lanes and handshake
    add_stim(MCU_WR, 1'b0, 24'h001234, 8'hA5, 8'h00, "lane_wr_hi");
    add_stim(MCU_WR, 1'b0, 24'h001235, 8'h3C, 8'h00, "lane_wr_lo");
    add_stim(MCU_RD, 1'b0, 24'h001234, 8'h00, 8'hA5, "lane_rd_hi");
    add_stim(MCU_RD, 1'b0, 24'h001235, 8'h00, 8'h3C, "lane_rd_lo");
    add_stim(MCU_WR, 1'b0, 24'h001235, 8'h77, 8'h00, "lane_rewrite_lo");
    add_stim(MCU_RD, 1'b0, 24'h001234, 8'h00, 8'hA5, "lane_keep_hi");
    add_stim(MCU_RD, 1'b0, 24'h001235, 8'h00, 8'h77, "lane_new_lo");
    // Console reads under both mappers
    add_stim(SNES_RD, 1'b0, 24'h7ABCDE, 8'h5A, 8'h5A, "hirom_rd_mask");
    add_stim(SNES_RD, 1'b0, 24'hC08001, 8'h81, 8'h81, "hirom_rd_odd");
    add_stim(SNES_RD, 1'b1, 24'h039ABC, 8'hC3, 8'hC3, "lorom_rd");
    add_stim(SNES_RD, 1'b1, 24'h45FFFF, 8'h96, 8'h96, "lorom_rd_mask");
    // Console writes that must leave ROM unchanged
    add_stim(SNES_WR, 1'b0, 24'h306123, 8'h6E, 8'h6E, "hirom_sram_wr");
    add_stim(SNES_WR, 1'b1, 24'h710456, 8'h2B, 8'h2B, "lorom_sram_wr");
    add_stim(SNES_WR, 1'b0, 24'h7ABCDE, 8'hFF, 8'h5A, "rom_wr_ignored");
    add_stim(COP_RD, 1'b0, 24'h001235, 8'h00, 8'h77, "cop_rd_lo");
    add_stim(COP_RD, 1'b0, 24'h0ABCDE, 8'h00, 8'h5A, "cop_rd_rom");
    add_stim(CHECK_OE, 1'b0, 24'hC08001, 8'h00, 8'h01, "oe_cart_rom");
    add_stim(CHECK_OE, 1'b0, 24'h001000, 8'h00, 8'h00, "oe_outside");
    add_stim(CHECK_OE, 1'b1, 24'h710456, 8'h00, 8'h01, "oe_cart_sram");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    entry_t      e;
    logic [7:0]  rd;
    logic [7:0]  sd;
    logic [7:0]  d;
    logic [23:0] a;
    logic [23:0] m;
    logic [3:0]  dly;
    logic [31:0] rng;

    reset            = 1'b1;
    snes_addr        = 24'h000000;
    snes_rd_n        = 1'b1;
    snes_wr_n        = 1'b1;
    snes_cpu_clk     = 1'b0;
    snes_din         = 8'h00;
    cfg.mapper       = 1'b0;
    cfg.rom_mask     = 24'h0FFFFF;
    cfg.saveram_mask = 24'h001FFF;
    mcu_req          = 1'b0;
    mcu_cmd          = '0;
    cop_req          = 1'b0;
    cop_addr         = 24'h000000;
    rng              = 32'd48;
    load_stim();

    repeat (3) @(posedge CLK2);
    #5;
    reset = 1'b0;
    step();
    check_region_flag("reset_mcu_ack", 1'b0, mcu_ack);
    check_region_flag("reset_cop_ack", 1'b0, cop_ack);
    check_region_flag("reset_we_n", 1'b1, psram.we_n);
    check_region_flag("reset_data_oe", 1'b0, snes_data_oe);

    foreach (stim_q[i]) begin
      e = stim_q[i];
      cfg.mapper = e.lorom;
      case (e.kind)
        MCU_WR: mcu_access(e.name, 1'b1, e.addr, e.data, rd);
        MCU_RD: begin
          mcu_access(e.name, 1'b0, e.addr, 8'h00, rd);
          check_byte(e.name, e.expected, rd);
        end
        COP_RD: begin
          cop_read(e.name, e.addr, rd);
          check_byte(e.name, e.expected, rd);
        end
        SNES_RD: begin
          mcu_access(e.name, 1'b1, map_addr(e.lorom, e.addr), e.data, rd);
          snes_cycle(e.addr, 1'b0, 8'h00, sd);
          check_byte(e.name, e.expected, sd);
        end
        SNES_WR: begin
          snes_cycle(e.addr, 1'b1, e.data, sd);
          mcu_access(e.name, 1'b0, map_addr(e.lorom, e.addr), 8'h00, rd);
          check_byte(e.name, e.expected, rd);
        end
        default: begin
          snes_addr = e.addr;
          snes_rd_n = 1'b0;
          step();
          check_region_flag(e.name, e.expected[0], snes_data_oe);
          check_region_flag({e.name, "_dir"}, 1'b1, snes_databus_dir);
          snes_rd_n = 1'b1;
          step();
          check_region_flag({e.name, "_off"}, 1'b0, snes_data_oe);
          check_region_flag({e.name, "_dir_off"}, 1'b0, snes_databus_dir);
        end
      endcase
    end

    // Host read held across a console read in HiROM banks 40-7F
    cfg.mapper = 1'b0;
    for (int n = 0; n < RAND_RUNS; n++) begin
      rng = lcg_next(rng);
      a   = {2'b01, rng[29:8]};
      rng = lcg_next(rng);
      d   = rng[23:16];
      rng = lcg_next(rng);
      dly = rng[19:16];
      m   = map_addr(1'b0, a);
      mcu_access("rand_preload", 1'b1, m, d, rd);
      fork
        snes_cycle(a, 1'b0, 8'h00, sd);
        begin
          repeat (dly + 5'd4) step();
          mcu_access("rand_mcu_rd", 1'b0, m, 8'h00, rd);
        end
      join
      check_byte($sformatf("rand_snes_rd_%0d", n), d, sd);
      check_byte($sformatf("rand_mcu_rd_%0d", n), d, rd);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
